/* flist.f */
+incdir+include
rtl/msx_pkg.sv
rtl/scc_bus_if.sv
rtl/scc_tone_seq.sv
rtl/scc_wave_ram.sv
rtl/scc_mixer.sv
rtl/scc_wave.sv
rtl/scc.sv
rtl/scc_top.sv
test/scc_checker.sv
test/tb_scc.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_scc -f flist.f -o tb_scc &&
./obj_dir/tb_scc | tee /dev/stderr | grep -c "^Everything OK$" > /dev/null &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* test/scc_golden.txt */
# name op a b c, fields in hex. wr rwr: slot addr byte. rd rrd desen destyp: slot addr expected
# cfg: slot mode chip. en: slot enable mask. snd: expected sound word
en_both en 3 0 0
rst_sound snd 0 0 0
rst_period rd 0 a0 0
rst_mask rd 1 af 0
t0_ch0 wr 0 00 10
t0_ch1 wr 0 20 f0
t0_ch2 wr 0 40 05
t0_ch3 wr 0 60 20
plus_on cfg 0 1 1
t4_plus wr 0 80 33
scc_on cfg 0 0 0
t4_drop wr 0 80 7f
t4_kept rd 0 80 33
vol0 wr 0 aa 1
vol1 wr 0 ab 2
vol2 wr 0 ac 3
vol3 wr 0 ad 4
vol4 wr 0 ae 5
mask_all wr 0 af 1f
mix_scc snd 11f 0 0
mask_part wr 0 af 0b
mix_mask snd 70 0 0
mask_back wr 0 af 1f
mode_only cfg 0 1 0
mix_mode_only snd 11f 0 0
plus_again cfg 0 1 1
mix_plus snd 17e 0 0
t4_neg wr 0 80 9c
t4_neg_rb rd 0 80 9c
mix_plus_neg snd fe8b 0 0
scc_back cfg 0 0 0
s1_t0 wr 1 00 40
s1_vol wr 1 aa f
s1_mask wr 1 af 1
mix_both snd 4df 0 0
en_s1 en 2 0 0
mix_s1 snd 3c0 0 0
en_none en 0 0 0
mix_none snd 0 0 0
vol_rb rd 0 ab 2
s1_vol_rb rd 1 aa f
rnd0 rwr 0 05 0
rnd1 rwr 1 7e 0
rnd0_rb rrd 0 05 0
rnd1_rb rrd 1 7e 0
desel_en desen 0 00 ff
desel_typ destyp 1 00 ff
per_lo wr 0 a0 34
per_hi wr 0 a1 05
per_lo_rb rd 0 a0 34
per_hi_rb rd 0 a1 05

/* test/tb_scc.sv */
`timescale 1ns/1ps

module scc_clock_gen #(
    parameter int HALF_NS = 2                   // Half of the 4 ns period
) (
    output logic clk
);
    initial clk = 1'b0;
    always #(HALF_NS) clk = ~clk;
endmodule

module tb_scc;

    localparam int MAX_TESTS = 64;              // Golden lines kept
    localparam int SND_WAIT  = 40;              // Cycles for a change to reach sound

    logic               cpu_bus;
    logic               rst;
    logic               clk_en;
    logic               rd;
    logic               wr;
    logic [7:0]         addr;
    logic [7:0]         wdata;
    msx_pkg::device_t   dev_typ;
    logic [1:0]         dev_num;
    logic               dev_en;
    logic               dev_mode;
    logic               dev_param;
    logic [1:0]         dev_enable;
    logic signed [15:0] sound;
    logic [7:0]         data;

    logic               check_stb;              // Strobe to the checker
    logic               check_snd;
    logic [15:0]        exp_val;
    logic [8*24-1:0]    cur_name;
    int                 pass_cnt;
    int                 fail_cnt;

    logic [8*24-1:0]    t_name [MAX_TESTS];     // Parsed golden lines
    logic [8*8-1:0]     t_op   [MAX_TESTS];
    logic [15:0]        t_a    [MAX_TESTS];
    logic [15:0]        t_b    [MAX_TESTS];
    logic [15:0]        t_c    [MAX_TESTS];
    logic [7:0]         rnd_mem [2][256];       // Random bytes written per slot
    logic [1:0]         mode_sh;                // Mode bit last configured per slot
    logic [1:0]         chip_sh;                // Chip bit last configured per slot
    int                 n_tests;
    int                 bad_ops = 0;
    int                 seed = 32'h2cde;
    int                 cycles = 0;
    int                 limit = 0;              // Zero until the golden file is read

    scc_clock_gen u_clk (.clk(cpu_bus));

    scc_top dut0 (
        .cpu_bus(cpu_bus), .rst(rst), .clk_en(clk_en), .rd(rd), .wr(wr),
        .addr(addr), .wdata(wdata), .dev_typ(dev_typ), .dev_num(dev_num),
        .dev_en(dev_en), .dev_mode(dev_mode), .dev_param(dev_param),
        .dev_enable(dev_enable), .sound(sound), .data(data)
    );

    scc_checker u_check (
        .clk(cpu_bus), .data(data), .sound(sound), .check_stb(check_stb),
        .check_snd(check_snd), .exp_val(exp_val), .test_name(cur_name),
        .pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
    );

    // Run limit from the number of golden lines
    always @(posedge cpu_bus) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt + 1);
            $display("Something failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge cpu_bus);
        #1;                                     // Inputs move just after the edge
    endtask

    task automatic idle();
        rd      = 1'b0;
        wr      = 1'b0;
        dev_en  = 1'b0;
        dev_typ = msx_pkg::DEV_NONE;            // Keeps the config port quiet
    endtask

    // Any SCC access also reloads the slot config, so keep it as last set
    task automatic select(input logic [1:0] slot, input logic [7:0] a);
        dev_typ   = msx_pkg::DEV_SCC;
        dev_num   = slot;
        dev_en    = 1'b1;
        dev_mode  = mode_sh[slot[0]];
        dev_param = chip_sh[slot[0]];
        addr      = a;
    endtask

    task automatic post_check(input logic [15:0] expv, input logic [8*24-1:0] nm,
                              input logic snd);
        exp_val   = expv;
        cur_name  = nm;
        check_snd = snd;
        check_stb = 1'b1;
        next_cycle();                           // Checker samples at the negedge
        check_stb = 1'b0;
    endtask

    task automatic write_byte(input logic [1:0] slot, input logic [7:0] a, input logic [7:0] d);
        select(slot, a);
        wdata = d;
        wr    = 1'b1;
        next_cycle();
        idle();
        next_cycle();                           // Write lands one cycle later
    endtask

    // how 0 plain read, 1 with dev_en low, 2 with another device type
    task automatic read_check(input logic [1:0] slot, input logic [7:0] a,
                              input logic [15:0] expv, input logic [8*24-1:0] nm, input int how);
        select(slot, a);
        if (how == 1)
            dev_en = 1'b0;
        if (how == 2)
            dev_typ = msx_pkg::DEV_PSG;
        rd = 1'b1;
        next_cycle();                           // Second cycle of rd
        post_check(expv, nm, 1'b0);
        idle();
    endtask

    task automatic configure(input logic [1:0] slot, input logic mode, input logic chip);
        mode_sh[slot[0]] = mode;
        chip_sh[slot[0]] = chip;
        dev_typ   = msx_pkg::DEV_SCC;
        dev_num   = slot;
        dev_en    = 1'b0;                       // Config only, no access
        dev_mode  = mode;
        dev_param = chip;
        next_cycle();
        idle();
    endtask

    task automatic load_golden(output int count);
        string           line;
        logic [8*24-1:0] nm;
        logic [8*8-1:0]  op;
        logic [15:0]     a;
        logic [15:0]     b;
        logic [15:0]     c;
        int              fd;
        int              rc;
        count = 0;
        fd = $fopen("test/scc_golden.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && count < MAX_TESTS) begin
                line = "";
                rc = $fgets(line, fd);
                // Comment and blank lines give fewer than five fields
                if (rc > 0 && $sscanf(line, "%s %s %h %h %h", nm, op, a, b, c) == 5) begin
                    t_name[count] = nm;
                    t_op[count]   = op;
                    t_a[count]    = a;
                    t_b[count]    = b;
                    t_c[count]    = c;
                    count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int i);
        logic [1:0] slot;
        logic [7:0] a;
        logic [7:0] rnd;
        logic       checked;
        slot    = t_a[i][1:0];
        a       = t_b[i][7:0];
        checked = 1'b1;
        case (t_op[i])
            "wr": begin
                write_byte(slot, a, t_c[i][7:0]);
                checked = 1'b0;
            end
            "rwr": begin
                rnd = 8'($random(seed));
                rnd_mem[slot[0]][a] = rnd;      // Expected value for the later read
                write_byte(slot, a, rnd);
                checked = 1'b0;
            end
            "rd":     read_check(slot, a, t_c[i], t_name[i], 0);
            "rrd":    read_check(slot, a, {8'h00, rnd_mem[slot[0]][a]}, t_name[i], 0);
            "desen":  read_check(slot, a, t_c[i], t_name[i], 1);
            "destyp": read_check(slot, a, t_c[i], t_name[i], 2);
            "cfg": begin
                configure(slot, t_b[i][0], t_c[i][0]);
                checked = 1'b0;
            end
            "en": begin
                dev_enable = t_a[i][1:0];
                checked    = 1'b0;
            end
            "snd": begin
                repeat (SND_WAIT) next_cycle();
                post_check(t_a[i], t_name[i], 1'b1);
            end
            default: begin
                $display("Unknown operation in golden line %0s", t_name[i]);
                bad_ops++;
            end
        endcase
        if (!checked)
            $display("done          %0s", t_name[i]);
    endtask

    initial begin
        rst        = 1'b1;
        clk_en     = 1'b1;                      // Sound ticks every cycle
        rd         = 1'b0;
        wr         = 1'b0;
        addr       = 8'h00;
        wdata      = 8'h00;
        dev_typ    = msx_pkg::DEV_NONE;
        dev_num    = 2'd0;
        dev_en     = 1'b0;
        dev_mode   = 1'b0;
        dev_param  = 1'b0;
        dev_enable = 2'b00;
        check_stb  = 1'b0;
        check_snd  = 1'b0;
        exp_val    = '0;
        cur_name   = '0;
        mode_sh    = 2'b00;
        chip_sh    = 2'b00;
        load_golden(n_tests);
        limit = n_tests * 64 + 100;
        repeat (10) @(posedge cpu_bus);
        #1;
        rst = 1'b0;
        if (n_tests == 0) begin
            $display("No tests could be read from test/scc_golden.txt");
            $display("Something failed");
        end else begin
            for (int i = 0; i < n_tests; i++)
                run_test(i);
            next_cycle();
            $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt + bad_ops);
            if (fail_cnt == 0 && bad_ops == 0)
                $display("Everything OK");
            else
                $display("Something failed");
        end
        $finish;
    end

endmodule

/* test/scc_checker.sv */
`timescale 1ns/1ps

module scc_checker (
    input  logic               clk,             // Testbench clock
    input  logic [7:0]         data,            // DUT read data
    input  logic signed [15:0] sound,           // DUT sound word
    input  logic               check_stb,       // Compare in this cycle
    input  logic               check_snd,       // Compare sound, else data
    input  logic [15:0]        exp_val,         // Expected value
    input  logic [8*24-1:0]    test_name,       // Name from the golden file
    output int                 pass_cnt,        // Matching checks so far
    output int                 fail_cnt         // Mismatches so far
);

    int          passes = 0;
    int          fails = 0;
    logic [15:0] actual;                        // Port picked by the check kind

    assign pass_cnt = passes;
    assign fail_cnt = fails;
    assign actual   = check_snd ? sound : {8'h00, data};

    // Half a cycle after the edge the DUT outputs have settled
    always @(negedge clk) begin
        if (check_stb) begin
            if (actual == exp_val) begin
                passes = passes + 1;
                $display("PASS          %0s", test_name);
            end else begin
                fails = fails + 1;
                $display("CHECK FAILED  %0s expected %h actual %h", test_name, exp_val, actual);
            end
        end
    end

endmodule

/* rtl/scc_top.sv */
`timescale 1ns/1ps

module scc_top (
    input  logic                cpu_bus,        // System clock
    input  logic                rst,            // Sync reset
    input  logic                clk_en,         // Sound tick
    input  logic                rd,             // CPU read level
    input  logic                wr,             // CPU write level
    input  logic [7:0]          addr,           // Slot byte address
    input  logic [7:0]          wdata,          // CPU write data
    input  msx_pkg::device_t    dev_typ,        // Device kind being addressed
    input  logic [1:0]          dev_num,        // Slot number
    input  logic                dev_en,         // Device access enable
    input  logic                dev_mode,       // SCC+ mode bit
    input  logic                dev_param,      // SCC+ chip bit
    input  logic [1:0]          dev_enable,     // Per-slot sound enable
    output logic signed [15:0]  sound,          // Mixed sound word
    output logic [7:0]          data            // CPU read data
);

    scc u_scc (
        .cpu_bus    (cpu_bus),
        .rst        (rst),
        .clk_en     (clk_en),
        .rd         (rd),
        .wr         (wr),
        .addr       (addr),
        .wdata      (wdata),
        .dev_typ    (dev_typ),
        .dev_num    (dev_num),
        .dev_en     (dev_en),
        .dev_mode   (dev_mode),
        .dev_param  (dev_param),
        .dev_enable (dev_enable),
        .sound      (sound),
        .data       (data)
    );

endmodule

/* rtl/scc.sv */
`timescale 1ns/1ps
`include "scc_macros.svh"

module scc (
    input  logic                cpu_bus,        // System clock
    input  logic                rst,            // Sync reset
    input  logic                clk_en,         // Sound tick
    input  logic                rd,             // CPU read level
    input  logic                wr,             // CPU write level
    input  logic [7:0]          addr,           // Slot byte address
    input  logic [7:0]          wdata,          // CPU write data
    input  msx_pkg::device_t    dev_typ,        // Device kind being addressed
    input  logic [1:0]          dev_num,        // Slot number
    input  logic                dev_en,         // Device access enable
    input  logic                dev_mode,       // SCC+ mode bit
    input  logic                dev_param,      // SCC+ chip bit
    input  logic [1:0]          dev_enable,     // Per-slot sound enable
    output logic signed [15:0]  sound,          // Mixed sound word
    output logic [7:0]          data            // CPU read data
);

    logic [`SCC_SLOTS-1:0] scc_mode;            // SCC+ mode per slot
    logic [`SCC_SLOTS-1:0] scc_plus;            // SCC+ chip per slot
    logic                  cs;                  // Any SCC selected
    logic [7:0]            slot_data [`SCC_SLOTS];
    msx_pkg::wave_t        slot_wave [`SCC_SLOTS];

    assign cs = dev_typ == msx_pkg::DEV_SCC && dev_en;

    // Configuration port, takes effect on the next clock
    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            scc_mode <= '0;
            scc_plus <= '0;
        end else if (dev_typ == msx_pkg::DEV_SCC && dev_num < 2'(`SCC_SLOTS)) begin
            scc_mode[dev_num[0]] <= dev_mode;
            scc_plus[dev_num[0]] <= dev_param;
        end
    end

    for (genvar i = 0; i < `SCC_SLOTS; i++) begin : g_slot
        scc_bus_if bus_i ();

        // Host side of the slot bus
        assign bus_i.clk_en = clk_en;
        assign bus_i.rd     = rd;
        assign bus_i.wr     = wr;
        assign bus_i.addr   = addr;
        assign bus_i.wdata  = wdata;
        assign bus_i.req    = cs && dev_num == 2'(i);   // Only the addressed slot

        scc_wave u_wave (
            .cpu_bus   (cpu_bus),
            .rst       (rst),
            .bus       (bus_i.device),
            .plus_chip (scc_plus[i]),
            .plus_mode (scc_mode[i]),
            .rdata     (slot_data[i]),
            .wave      (slot_wave[i])
        );
    end

    assign data = (cs && rd) ? slot_data[dev_num[0]] : 8'hFF;  // Open bus when idle

    // Sign-extend and add the enabled slots
    assign sound = (dev_enable[0] ? 16'(slot_wave[0]) : 16'sd0) +
                   (dev_enable[1] ? 16'(slot_wave[1]) : 16'sd0);

endmodule

/* rtl/scc_wave.sv */
`timescale 1ns/1ps
`include "scc_macros.svh"

module scc_wave (
    input  logic           cpu_bus,             // System clock
    input  logic           rst,                 // Sync reset
    scc_bus_if.device      bus,                 // CPU access for this slot
    input  logic           plus_chip,           // Slot holds an SCC+ chip
    input  logic           plus_mode,           // SCC+ mode selected
    output logic [7:0]     rdata,               // Read data, one cycle behind addr
    output msx_pkg::wave_t wave                 // Slot sound
);

    msx_pkg::period_t          periods [`SCC_CHANNELS];
    msx_pkg::volume_t          volumes [`SCC_CHANNELS];
    logic [`SCC_CHANNELS-1:0]  mask;
    logic [`SCC_CHANNELS-1:0]  period_wr;       // Period write strobes
    logic [`SCC_CHANNELS-1:0]  vol_wr;          // Volume write strobes
    logic                      mask_wr;
    logic                      ram_wr;
    logic                      wr_hit;          // Selected write this clock
    logic                      plus_on;         // SCC+ behaviour in effect
    logic [7:0]                roff;            // Offset into register space
    logic [2:0]                vidx;            // Volume index
    logic [7:0]                ram_q;           // Registered RAM byte
    logic [7:0]                reg_val;         // Register byte at addr
    logic [7:0]                reg_q;           // Registered register byte
    logic                      ram_sel_q;       // Last address was in the tables

    scc_sample_if smp_if ();

    // SCC+ features need an SCC+ chip running in SCC+ mode
    assign plus_on = plus_chip && plus_mode;
    assign wr_hit  = bus.req && bus.wr;
    assign roff    = bus.addr - 8'hA0;          // Wraps high below 0xA0
    assign vidx    = 3'(roff - 8'd10);

    // Write decode
    always_comb begin
        period_wr = '0;
        vol_wr    = '0;
        ram_wr    = wr_hit && bus.addr < 8'hA0 && (bus.addr < 8'h80 || plus_on);
        mask_wr   = wr_hit && roff == 8'd15;
        if (wr_hit && roff < 8'd10)
            period_wr[roff[3:1]] = 1'b1;        // Two bytes per channel
        if (wr_hit && roff >= 8'd10 && roff < 8'd15)
            vol_wr[vidx] = 1'b1;
    end

    // Register read value
    always_comb begin
        reg_val = 8'h00;                        // Unused space reads zero
        if (roff < 8'd10)
            reg_val = roff[0] ? 8'(periods[roff[3:1]][`SCC_PERIOD_BITS-1:8])
                              : periods[roff[3:1]][7:0];
        else if (roff < 8'd15)
            reg_val = 8'(volumes[vidx]);
        else if (roff == 8'd15)
            reg_val = 8'(mask);
    end

    always_ff @(posedge cpu_bus) begin
        reg_q     <= reg_val;
        ram_sel_q <= bus.addr < 8'hA0;
    end

    assign rdata = ram_sel_q ? ram_q : reg_q;   // Both sides already registered

    scc_tone_seq u_seq (
        .cpu_bus   (cpu_bus),
        .rst       (rst),
        .clk_en    (bus.clk_en),
        .period_wr (period_wr),
        .wdata     (bus.wdata),
        .nib_hi    (bus.addr[0]),               // Odd address is the high nibble
        .plus_mode (plus_on),
        .periods   (periods),
        .smp       (smp_if.seq)
    );

    scc_wave_ram u_ram (
        .cpu_bus (cpu_bus),
        .wr_en   (ram_wr),
        .waddr   (bus.addr),
        .wdata   (bus.wdata),
        .caddr   (bus.addr),
        .cdata   (ram_q),
        .smp     (smp_if.ram)
    );

    scc_mixer u_mix (
        .cpu_bus (cpu_bus),
        .rst     (rst),
        .vol_wr  (vol_wr),
        .mask_wr (mask_wr),
        .wdata   (bus.wdata),
        .smp     (smp_if.mix),
        .volumes (volumes),
        .mask    (mask),
        .wave    (wave)
    );

    // The CPU never reads and writes a slot in the same clock
    a_rd_wr: assert property (@(posedge cpu_bus) disable iff (rst)
        bus.req |-> !(bus.rd && bus.wr));

endmodule

/* rtl/scc_mixer.sv */
`timescale 1ns/1ps
`include "scc_macros.svh"

module scc_mixer (
    input  logic                     cpu_bus,                   // System clock
    input  logic                     rst,                       // Sync reset
    input  logic [`SCC_CHANNELS-1:0] vol_wr,                    // Volume write strobes
    input  logic                     mask_wr,                   // Mask write strobe
    input  logic [7:0]               wdata,                     // CPU write byte
    scc_sample_if.mix                smp,                       // Incoming samples
    output msx_pkg::volume_t         volumes [`SCC_CHANNELS],   // Read-back of volumes
    output logic [`SCC_CHANNELS-1:0] mask,                      // Channel enable bits
    output msx_pkg::wave_t           wave                       // Slot output
);

    msx_pkg::wave_t    acc;                     // Running sum of one round
    msx_pkg::volume_t  vol_sel;                 // Volume of the arriving sample
    logic signed [12:0] prod;                   // Sample times volume
    logic signed [12:0] term;                   // Product after masking

    assign vol_sel = volumes[smp.sample_ch];
    assign prod    = smp.sample * $signed({1'b0, vol_sel});     // Volume is unsigned
    assign term    = mask[smp.sample_ch] ? prod : 13'sd0;        // Masked channels add nothing

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            for (int i = 0; i < `SCC_CHANNELS; i++)
                volumes[i] <= '0;
            mask <= '0;
            acc  <= '0;
            wave <= '0;
        end else begin
            for (int i = 0; i < `SCC_CHANNELS; i++) begin
                if (vol_wr[i])
                    volumes[i] <= wdata[3:0];
            end
            if (mask_wr)
                mask <= wdata[`SCC_CHANNELS-1:0];
            if (smp.sample_valid) begin
                if (smp.sample_ch == 3'(`SCC_CHANNELS - 1)) begin
                    wave <= acc + term;                 // Round done, publish
                    acc  <= '0;
                end else begin
                    acc <= acc + term;
                end
            end
        end
    end

    // The sequencer only names real channels
    a_sample_ch: assert property (@(posedge cpu_bus) disable iff (rst)
        smp.sample_valid |-> smp.sample_ch < 3'(`SCC_CHANNELS));

endmodule

/* rtl/scc_wave_ram.sv */
`timescale 1ns/1ps
`include "scc_macros.svh"

module scc_wave_ram (
    input  logic       cpu_bus,                 // System clock
    input  logic       wr_en,                   // CPU write strobe
    input  logic [7:0] waddr,                   // CPU write address
    input  logic [7:0] wdata,                   // CPU write data
    input  logic [7:0] caddr,                   // CPU read address
    output logic [7:0] cdata,                   // Registered CPU read data
    scc_sample_if.ram  smp                      // Sequencer port
);

    localparam int BYTES = `SCC_CHANNELS * `SCC_TABLE_DEPTH;    // 160 bytes

    logic [7:0] mem [BYTES];                    // Five tables back to back

    // CPU port, write and registered read
    always_ff @(posedge cpu_bus) begin
        if (wr_en)
            mem[waddr] <= wdata;
        cdata <= (caddr < 8'(BYTES)) ? mem[caddr] : 8'h00;   // Register space reads elsewhere
    end

    // Sequencer port returns one cycle after the strobe
    always_ff @(posedge cpu_bus) begin
        smp.sample_valid <= smp.rd_strobe;
        smp.sample_ch    <= smp.ch;
        if (smp.rd_strobe)
            smp.sample <= mem[smp.raddr];
    end

    // The decoder never writes into register space
    a_waddr_range: assert property (@(posedge cpu_bus)
        wr_en |-> waddr < 8'(BYTES));

endmodule

/* rtl/scc_tone_seq.sv */
`timescale 1ns/1ps
`include "scc_macros.svh"

module scc_tone_seq (
    input  logic                      cpu_bus,                  // System clock
    input  logic                      rst,                      // Sync reset
    input  logic                      clk_en,                   // Sound tick
    input  logic [`SCC_CHANNELS-1:0]  period_wr,                // One strobe per channel
    input  logic [7:0]                wdata,                    // CPU write byte
    input  logic                      nib_hi,                   // High nibble write
    input  logic                      plus_mode,                // SCC+ table mapping
    output msx_pkg::period_t          periods [`SCC_CHANNELS],  // Read-back of periods
    scc_sample_if.seq                 smp                       // Table read requests
);

    localparam int PH_BITS = $clog2(`SCC_TABLE_DEPTH);          // Phase width

    msx_pkg::period_t   cnt   [`SCC_CHANNELS];                  // Down-counters
    logic [PH_BITS-1:0] phase [`SCC_CHANNELS];                  // Table position per channel
    logic [2:0]         ch;                                     // Round-robin channel
    logic [2:0]         tbl;                                    // Table to read for ch

    // Plain SCC has only four tables, channel 4 shares table 3
    assign tbl = (ch == 3'd4 && !plus_mode) ? 3'd3 : ch;

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            for (int i = 0; i < `SCC_CHANNELS; i++) begin
                periods[i] <= '0;
                cnt[i]     <= '0;
                phase[i]   <= '0;
            end
            ch            <= '0;
            smp.ch        <= '0;
            smp.raddr     <= '0;
            smp.rd_strobe <= 1'b0;
        end else begin
            for (int i = 0; i < `SCC_CHANNELS; i++) begin
                if (period_wr[i]) begin
                    if (nib_hi)
                        periods[i][`SCC_PERIOD_BITS-1:8] <= wdata[`SCC_PERIOD_BITS-9:0];
                    else
                        periods[i][7:0] <= wdata;           // Low byte, two nibbles
                end
                if (clk_en && periods[i] != '0) begin       // Zero period holds the phase
                    if (cnt[i] == '0) begin
                        cnt[i]   <= periods[i];             // Reload
                        phase[i] <= phase[i] + 1'b1;        // Next table step
                    end else begin
                        cnt[i] <= cnt[i] - 1'b1;
                    end
                end
            end
            smp.rd_strobe <= clk_en;                        // One read per tick
            if (clk_en) begin
                smp.raddr <= {tbl, phase[ch]};              // Table base plus phase
                smp.ch    <= ch;
                ch        <= (ch == 3'(`SCC_CHANNELS - 1)) ? 3'd0 : ch + 3'd1;
            end
        end
    end

    // Decoder hits at most one period register per write
    a_period_wr: assert property (@(posedge cpu_bus) disable iff (rst)
        $onehot0(period_wr));

endmodule

/* rtl/scc_bus_if.sv */
`timescale 1ns/1ps

// CPU access to one slot
interface scc_bus_if;
    logic       clk_en;                         // Sound tick
    logic       rd;                             // Read level
    logic       wr;                             // Write level
    logic [7:0] addr;                           // Slot byte address
    logic [7:0] wdata;                          // Write data
    logic       req;                            // Chip select for this slot

    modport host   (output clk_en, rd, wr, addr, wdata, req);
    modport device (input  clk_en, rd, wr, addr, wdata, req);
endinterface

// Sample path inside a slot
interface scc_sample_if;
    logic [2:0]       ch;                       // Channel of the pending table read
    logic [7:0]       raddr;                    // Wave RAM byte address
    logic             rd_strobe;                // Table read request
    msx_pkg::sample_t sample;                   // Returned table entry
    logic             sample_valid;             // Sample present this cycle
    logic [2:0]       sample_ch;                // Channel the sample belongs to

    modport seq (output ch, raddr, rd_strobe);
    modport ram (input  ch, raddr, rd_strobe, output sample, sample_valid, sample_ch);
    modport mix (input  sample, sample_valid, sample_ch);
endinterface

/* rtl/msx_pkg.sv */
`include "scc_macros.svh"

package msx_pkg;

    // Device kinds on the configuration port
    typedef enum logic [1:0] {
        DEV_NONE = 2'd0,                        // Nothing selected
        DEV_SCC  = 2'd1,                        // Wavetable sound chip
        DEV_PSG  = 2'd2,                        // Programmable sound generator
        DEV_OPL  = 2'd3                         // FM sound chip
    } device_t;

    // Signed wave table entry
    typedef logic signed [7:0] sample_t;

    // Channel volume, 0 mutes the channel
    typedef logic [3:0] volume_t;

    // Tone period in clk_en ticks per table step
    typedef logic [`SCC_PERIOD_BITS-1:0] period_t;

    // Signed slot output, five channels of sample times volume
    typedef logic signed [14:0] wave_t;

endpackage

/* include/scc_macros.svh */
`ifndef SCC_MACROS_SVH
`define SCC_MACROS_SVH

// SCC slots behind the CPU bus port
`define SCC_SLOTS 2

// Tone channels in each slot
`define SCC_CHANNELS 5

// Signed bytes in each wave table
`define SCC_TABLE_DEPTH 32

// Period register width, split over a low byte and a high nibble
`define SCC_PERIOD_BITS 12

`endif
